// File: Bender.yml
package:
  name: mc_scope

sources:
  - include_dirs:
      - include
    files:
      - hdl/scope_pkg.sv
      - hdl/slot_scheduler.sv
      - hdl/frame_packer.sv
      - hdl/capture_fifo.sv
      - hdl/credit_tx.sv
      - hdl/mc_scope_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mc_scope_props.sv
      - verification/mc_scope_tb.sv

// File: filelist.f
+incdir+include
hdl/scope_pkg.sv
hdl/slot_scheduler.sv
hdl/frame_packer.sv
hdl/capture_fifo.sv
hdl/credit_tx.sv
hdl/mc_scope_top.sv
verification/mc_scope_props.sv
verification/mc_scope_tb.sv

// File: hdl/capture_fifo.sv
//####################
// Capture FIFO
// Circular word buffer that reports its free space
//####################
`default_nettype none
`include "scope_defs.svh"

module capture_fifo (
    input  logic clock,
    input  logic reset,
    input  logic write,
    input  scope_pkg::scope_word_t write_word,
    input  logic read,
    output scope_pkg::scope_word_t read_word,
    output logic empty,
    output logic [$clog2(`SCOPE_FIFO_DEPTH+1)-1:0] free_count
);

    import scope_pkg::*;

    localparam int ADDR_WIDTH = $clog2(`SCOPE_FIFO_DEPTH);
    localparam int COUNT_WIDTH = $clog2(`SCOPE_FIFO_DEPTH + 1);

    scope_word_t mem [`SCOPE_FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0] write_ptr;
    logic [ADDR_WIDTH-1:0] read_ptr;
    logic [COUNT_WIDTH-1:0] occupancy;
    logic do_write;
    logic do_read;

    assign do_read = read && !empty;
    assign do_write = write && (occupancy != COUNT_WIDTH'(`SCOPE_FIFO_DEPTH));

    assign empty = occupancy == '0;
    assign read_word = mem[read_ptr];
    assign free_count = COUNT_WIDTH'(`SCOPE_FIFO_DEPTH) - occupancy;

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[write_ptr] <= write_word;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clock) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            occupancy <= '0;
        end else begin
            if (do_write) write_ptr <= write_ptr + 1'b1;
            if (do_read) read_ptr <= read_ptr + 1'b1;
            occupancy <= occupancy + COUNT_WIDTH'(do_write) - COUNT_WIDTH'(do_read);
        end
    end

endmodule

`default_nettype wire

// File: hdl/credit_tx.sv
//####################
// Credit transmitter
// Sends FIFO words while receiver credits remain
//####################
`default_nettype none
`include "scope_defs.svh"

module credit_tx (
    input  logic clock,
    input  logic reset,
    input  logic empty,
    input  scope_pkg::scope_word_t read_word,
    input  logic credit_return,
    output logic read,
    output logic out_valid,
    output scope_pkg::scope_word_t out_word
);

    localparam int CREDIT_WIDTH = $clog2(`SCOPE_CREDITS + 1);

    logic [CREDIT_WIDTH-1:0] credits;

    // Pop whenever a word waits and the receiver has room for it
    assign read = !empty && (credits != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CREDIT_WIDTH'(`SCOPE_CREDITS);
            out_valid <= 1'b0;
        end else begin
            // A send and a returned credit in one cycle cancel out
            credits <= credits - CREDIT_WIDTH'(read) + CREDIT_WIDTH'(credit_return);
            out_valid <= read;
        end
    end

    always_ff @(posedge clock) begin
        if (read) begin
            out_word <= read_word;
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_packer.sv
//####################
// Frame packer
// Prefixes each frame with a header and drops frames that do not fit
//####################
`default_nettype none
`include "scope_defs.svh"

module frame_packer (
    input  logic clock,
    input  logic reset,
    input  logic sample_valid,
    input  scope_pkg::channel_t sample_channel,
    input  logic [`SCOPE_SAMPLE_WIDTH-1:0] sample_value,
    input  logic [$clog2(`SCOPE_FIFO_DEPTH+1)-1:0] free_count,
    output logic write,
    output scope_pkg::scope_word_t write_word,
    output logic [15:0] dropped_frames
);

    import scope_pkg::*;

    logic [23:0] frame_index;
    logic keep_frame;
    logic hold_pending;
    logic [`SCOPE_SAMPLE_WIDTH-1:0] hold_value;
    logic first_sample;
    logic frame_fits;

    assign first_sample = sample_valid && (sample_channel == channel_t'(0));
    // A frame needs room for its header plus every channel
    assign frame_fits = free_count >= `SCOPE_N_CHANNELS + 1;

    always_ff @(posedge clock) begin
        if (reset) begin
            write <= 1'b0;
            frame_index <= '0;
            keep_frame <= 1'b0;
            hold_pending <= 1'b0;
            dropped_frames <= '0;
        end else begin
            write <= 1'b0;
            hold_pending <= 1'b0;
            if (first_sample) begin
                // Index advances for kept and dropped frames alike
                frame_index <= frame_index + 1'b1;
                keep_frame <= frame_fits;
                hold_pending <= frame_fits;
                write <= frame_fits;
                if (!frame_fits) begin
                    dropped_frames <= dropped_frames + 1'b1;
                end
            end else if (hold_pending) begin
                write <= 1'b1;
            end else if (sample_valid) begin
                write <= keep_frame;
            end
        end
    end

    // Header goes out first, channel 0 waits one cycle in the holding register
    always_ff @(posedge clock) begin
        if (first_sample) begin
            hold_value <= sample_value;
            write_word.header <= '{kind: 1'b1, channel_count: 7'(`SCOPE_N_CHANNELS),
                                   frame_index: frame_index};
        end else if (hold_pending) begin
            write_word.sample <= '{kind: 1'b0, channel: 7'd0, value: hold_value};
        end else if (sample_valid) begin
            write_word.sample <= '{kind: 1'b0, channel: 7'(sample_channel),
                                   value: sample_value};
        end
    end

endmodule

`default_nettype wire

// File: hdl/mc_scope_top.sv
//####################
// Scope front end top
// Scheduler, packer, capture FIFO and credit transmitter
//####################
`default_nettype none
`include "scope_defs.svh"

module mc_scope_top (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic [`SCOPE_N_CHANNELS-1:0][`SCOPE_SAMPLE_WIDTH-1:0] adc_data,
    input  logic credit_return,
    output logic out_valid,
    output scope_pkg::scope_word_t out_word,
    output logic [15:0] dropped_frames
);

    import scope_pkg::*;

    logic sample_valid;
    channel_t sample_channel;
    logic [`SCOPE_SAMPLE_WIDTH-1:0] sample_value;

    logic fifo_write;
    scope_word_t fifo_write_word;
    logic [$clog2(`SCOPE_FIFO_DEPTH+1)-1:0] free_count;

    logic fifo_read;
    scope_word_t fifo_read_word;
    logic fifo_empty;

    slot_scheduler i_scheduler (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .adc_data(adc_data),
        .sample_valid(sample_valid),
        .sample_channel(sample_channel),
        .sample_value(sample_value)
    );

    frame_packer i_packer (
        .clock(clock),
        .reset(reset),
        .sample_valid(sample_valid),
        .sample_channel(sample_channel),
        .sample_value(sample_value),
        .free_count(free_count),
        .write(fifo_write),
        .write_word(fifo_write_word),
        .dropped_frames(dropped_frames)
    );

    capture_fifo i_fifo (
        .clock(clock),
        .reset(reset),
        .write(fifo_write),
        .write_word(fifo_write_word),
        .read(fifo_read),
        .read_word(fifo_read_word),
        .empty(fifo_empty),
        .free_count(free_count)
    );

    credit_tx i_tx (
        .clock(clock),
        .reset(reset),
        .empty(fifo_empty),
        .read_word(fifo_read_word),
        .credit_return(credit_return),
        .read(fifo_read),
        .out_valid(out_valid),
        .out_word(out_word)
    );

endmodule

`default_nettype wire

// File: hdl/scope_pkg.sv
//####################
// Scope types
// Output word with header and sample views
//####################
`default_nettype none

package scope_pkg;

    typedef logic [2:0] channel_t;

    // Frame header, kind is 1
    typedef struct packed {
        logic        kind;
        logic [6:0]  channel_count;
        logic [23:0] frame_index;
    } header_view_t;

    // One channel sample, kind is 0
    typedef struct packed {
        logic        kind;
        logic [6:0]  channel;
        logic [23:0] value;
    } sample_view_t;

    // Bit 31 tells the receiver which view applies
    typedef union packed {
        header_view_t header;
        sample_view_t sample;
    } scope_word_t;

endpackage

`default_nettype wire

// File: hdl/slot_scheduler.sv
//####################
// Slot scheduler
// Period counter that captures each channel at its own slot
//####################
`default_nettype none
`include "scope_defs.svh"

module slot_scheduler (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic [`SCOPE_N_CHANNELS-1:0][`SCOPE_SAMPLE_WIDTH-1:0] adc_data,
    output logic sample_valid,
    output scope_pkg::channel_t sample_channel,
    output logic [`SCOPE_SAMPLE_WIDTH-1:0] sample_value
);

    import scope_pkg::*;

    localparam int COUNT_WIDTH = $clog2(`SCOPE_PERIOD);

    logic [COUNT_WIDTH-1:0] period_count;
    logic slot_hit;
    channel_t slot_channel;

    // Compare the counter against every channel slot
    always_comb begin
        slot_hit = 1'b0;
        slot_channel = '0;
        for (int k = 0; k < `SCOPE_N_CHANNELS; k++) begin
            if (period_count == COUNT_WIDTH'(`SCOPE_FIRST_SLOT + k * `SCOPE_SLOT_STEP)) begin
                slot_hit = 1'b1;
                slot_channel = channel_t'(k);
            end
        end
    end

    // Counter only moves on enabled cycles
    always_ff @(posedge clock) begin
        if (reset) begin
            period_count <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= enable && slot_hit;
            if (enable) begin
                if (period_count == COUNT_WIDTH'(`SCOPE_PERIOD - 1)) begin
                    period_count <= '0;
                end else begin
                    period_count <= period_count + 1'b1;
                end
            end
        end
    end

    // Sample stays put until the next slot overwrites it
    always_ff @(posedge clock) begin
        if (enable && slot_hit) begin
            sample_channel <= slot_channel;
            sample_value <= adc_data[slot_channel];
        end
    end

endmodule

`default_nettype wire

// File: include/scope_defs.svh
//####################
// Scope front end parameters
// Channel timing, sample format and buffer sizes
//####################
`ifndef SCOPE_DEFS_SVH
`define SCOPE_DEFS_SVH

// Sampled channels and width of one input value
`define SCOPE_N_CHANNELS 6
`define SCOPE_SAMPLE_WIDTH 24

// Sampling period in enabled cycles
`define SCOPE_PERIOD 64

// Channel k is captured at FIRST_SLOT + k * SLOT_STEP
`define SCOPE_FIRST_SLOT 10
`define SCOPE_SLOT_STEP 2

// Capture buffer size and receiver credits
`define SCOPE_FIFO_DEPTH 16
`define SCOPE_CREDITS 4

`endif

// File: verification/mc_scope_props.sv
//####################
// Credit transmitter assertions
// Credit limits and output state after reset
//####################
`default_nettype none
`include "scope_defs.svh"

module mc_scope_props (
    input logic clock,
    input logic reset,
    input logic read,
    input logic out_valid,
    input logic [$clog2(`SCOPE_CREDITS+1)-1:0] credits
);

    localparam int CREDIT_WIDTH = $clog2(`SCOPE_CREDITS + 1);

    int failure_count = 0;

    // The word now on the output was popped while a credit was held
    assert property (@(posedge clock) disable iff (reset) out_valid |-> $past(credits) != '0)
        else begin
            $error("word sent without a receiver credit");
            failure_count++;
        end

    assert property (@(posedge clock) disable iff (reset)
                     credits <= CREDIT_WIDTH'(`SCOPE_CREDITS))
        else begin
            $error("credit count above the receiver buffer size");
            failure_count++;
        end

    assert property (@(posedge clock) $fell(reset) |-> !out_valid && !read)
        else begin
            $error("transmitter active in the cycle after reset");
            failure_count++;
        end

endmodule

bind credit_tx mc_scope_props i_props (
    .clock(clock),
    .reset(reset),
    .read(read),
    .out_valid(out_valid),
    .credits(credits)
);

`default_nettype wire

// File: verification/mc_scope_tb.sv
//####################
// Scope front end testbench
// Random inputs, credit receiver model and frame checker
//####################
`default_nettype none
`include "scope_defs.svh"

module mc_scope_tb;

    import scope_pkg::*;

    localparam int CLOCK_PERIOD = 8;
    localparam int RUN_PERIODS = 200;
    localparam int MAX_FRAMES = 256;
    localparam int DRAIN_CYCLES = 64;
    // Enable is high nine cycles in ten, so a period lasts about 10/9 of its length
    localparam int RUN_CYCLES = RUN_PERIODS * `SCOPE_PERIOD * 10 / 9;
    localparam int WATCHDOG_TIME = 3 * RUN_CYCLES * CLOCK_PERIOD;

    logic clock;
    logic reset;
    logic enable;
    logic [`SCOPE_N_CHANNELS-1:0][`SCOPE_SAMPLE_WIDTH-1:0] adc_data;
    logic credit_return;
    logic out_valid;
    scope_word_t out_word;
    logic [15:0] dropped_frames;

    logic [31:0] rng_state;
    logic [23:0] recorded [MAX_FRAMES][`SCOPE_N_CHANNELS];
    int model_count;
    int model_frame;
    int next_index;
    int periods_done;
    int received_count;
    int returned_count;
    int wait_count;
    int quiet_cycles;
    int seen_count;
    logic in_frame;
    logic seen_header;
    int sample_pos;
    int current_frame;
    int last_index;
    int skipped_total;
    int expected_drops;
    int mismatch_count;
    int error_count;
    int assert_failures;

    mc_scope_top i_dut (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .adc_data(adc_data),
        .credit_return(credit_return),
        .out_valid(out_valid),
        .out_word(out_word),
        .dropped_frames(dropped_frames)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        $display("mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
        mismatch_count++;
    endtask

    task automatic note_error(input string what);
        $display("error at time %0t: %s", $time, what);
        error_count++;
    endtask

    // Mirror of the period counter, records each captured value under its frame index
    task automatic track_slots();
        for (int k = 0; k < `SCOPE_N_CHANNELS; k++) begin
            if (model_count == `SCOPE_FIRST_SLOT + k * `SCOPE_SLOT_STEP) begin
                if (k == 0) begin
                    model_frame = next_index;
                    next_index++;
                end
                if (model_frame < MAX_FRAMES) recorded[model_frame][k] = adc_data[k];
            end
        end
        if (model_count == `SCOPE_PERIOD - 1) begin
            model_count = 0;
            periods_done++;
        end else begin
            model_count++;
        end
    endtask

    task automatic check_word(input scope_word_t word);
        if (word.header.kind) begin
            if (in_frame) note_error($sformatf("header after %0d samples of frame", sample_pos));
            if (word.header.channel_count != 7'(`SCOPE_N_CHANNELS)) begin
                note_mismatch("header channel_count", word.header.channel_count,
                              `SCOPE_N_CHANNELS);
            end
            if (seen_header && int'(word.header.frame_index) <= last_index) begin
                note_error($sformatf("frame index %0d does not follow %0d",
                                     word.header.frame_index, last_index));
            end else begin
                skipped_total += int'(word.header.frame_index) - (seen_header ? last_index + 1 : 0);
            end
            last_index = int'(word.header.frame_index);
            current_frame = last_index;
            seen_header = 1'b1;
            in_frame = 1'b1;
            sample_pos = 0;
        end else if (!in_frame) begin
            note_error("sample word arrived outside a frame");
        end else begin
            if (int'(word.sample.channel) != sample_pos) begin
                note_mismatch("sample channel", word.sample.channel, sample_pos);
            end
            if (current_frame >= next_index || current_frame >= MAX_FRAMES) begin
                note_error($sformatf("frame %0d was never captured", current_frame));
            end else if (word.sample.value != recorded[current_frame][sample_pos]) begin
                note_mismatch("sample value", word.sample.value,
                              recorded[current_frame][sample_pos]);
            end
            sample_pos++;
            if (sample_pos == `SCOPE_N_CHANNELS) in_frame = 1'b0;
        end
    endtask

    // Inputs for the next cycle, credits go back after a random wait per word
    task automatic drive_inputs(input logic run);
        rng_state = xorshift32(rng_state);
        enable = run && (rng_state % 10 != 0);
        for (int k = 0; k < `SCOPE_N_CHANNELS; k++) begin
            rng_state = xorshift32(rng_state);
            adc_data[k] = rng_state[`SCOPE_SAMPLE_WIDTH-1:0];
        end
        credit_return = 1'b0;
        if (received_count > returned_count) begin
            if (wait_count == 0) begin
                credit_return = 1'b1;
                returned_count++;
                rng_state = xorshift32(rng_state);
                wait_count = rng_state % 13;
            end else begin
                wait_count--;
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        if (reset) begin
            model_count = 0;
        end else begin
            if (enable) track_slots();
            if (out_valid === 1'b1) begin
                received_count++;
                if (next_index == 0) note_error("output word before the first frame was captured");
                if (received_count - returned_count > `SCOPE_CREDITS) begin
                    note_error($sformatf("receiver buffer overflow with %0d words held",
                                         received_count - returned_count));
                end
                check_word(out_word);
            end else if ($isunknown(out_valid)) begin
                note_error("out_valid is unknown after reset");
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the run finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rng_state = 32'h4b41_c4c1;
        reset = 1'b1;
        enable = 1'b0;
        adc_data = '0;
        credit_return = 1'b0;
        model_count = 0;
        model_frame = 0;
        next_index = 0;
        periods_done = 0;
        received_count = 0;
        returned_count = 0;
        in_frame = 1'b0;
        seen_header = 1'b0;
        sample_pos = 0;
        current_frame = 0;
        last_index = 0;
        skipped_total = 0;
        mismatch_count = 0;
        error_count = 0;
        wait_count = xorshift32(rng_state) % 13;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
        if (dropped_frames !== 16'd0) note_mismatch("dropped_frames", dropped_frames, 0);
        while (periods_done < RUN_PERIODS) begin
            drive_inputs(1'b1);
            @(posedge clock);
            #1;
        end
        // Enable stays low while the FIFO drains and every credit comes back
        quiet_cycles = 0;
        seen_count = received_count;
        while (quiet_cycles < DRAIN_CYCLES) begin
            drive_inputs(1'b0);
            @(posedge clock);
            #1;
            if (received_count == seen_count && received_count == returned_count) begin
                quiet_cycles++;
            end else begin
                quiet_cycles = 0;
            end
            seen_count = received_count;
        end
        if (in_frame) note_error($sformatf("last frame stopped after %0d samples", sample_pos));
        // Frames after the last header never arrived, so they count as skipped too
        expected_drops = skipped_total + next_index - (seen_header ? last_index + 1 : 0);
        if (dropped_frames !== 16'(expected_drops)) begin
            note_mismatch("dropped_frames", dropped_frames, expected_drops);
        end
        assert_failures = i_dut.i_tx.i_props.failure_count;
        $display("Run done: %0d frames, %0d words, %0d mismatches, %0d other errors, %0d %s",
                 next_index, received_count, mismatch_count, error_count, assert_failures,
                 "assertion failures");
        if (mismatch_count == 0 && error_count == 0 && assert_failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
